// ==== Makefile ====
BIN  := obj_dir/Vintra4_tb
SRCS := $(wildcard design/*.sv) dv/intra4_tb.sv dv/intra4_model.svh

.PHONY: all run clean

all: run

$(BIN): intra4_top.f $(SRCS)
	verilator --binary --timing --assert --top-module intra4_tb -f intra4_top.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/intra4_context.sv ====
/*
 * Reconstructed macroblock store
 * Supplies the current subblock's source and its neighbor context
 */
module intra4_context (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    store_en_i,
    input  intra4_pkg::blk_idx_t    blk_idx_i,
    input  intra4_pkg::blk4_t       best_blk_i,
    input  intra4_pkg::mb_t         src_i,
    input  intra4_pkg::pix_t        top_left_i,
    input  intra4_pkg::pix_t [15:0] top_i,
    input  intra4_pkg::pix_t [15:0] left_i,
    output intra4_pkg::ctx_t        ctx_o,
    output intra4_pkg::blk4_t       src_blk_o,
    output intra4_pkg::mb_t         yout_o
);

    intra4_pkg::mb_t recon;

    // Subblock position and its upper and left neighbors
    logic [1:0] by;
    logic [1:0] bx;
    logic [1:0] by_up;
    logic [1:0] bx_lf;

    assign by    = blk_idx_i[3:2];
    assign bx    = blk_idx_i[1:0];
    assign by_up = by - 2'd1;
    assign bx_lf = bx - 2'd1;

    // Pixel (r, c) of subblock (by, bx) sits at address {by, r, bx, c}
    always_comb begin
        for (int i = 0; i < intra4_pkg::BLK_ROWS; i++) begin
            if (by == 2'd0) begin
                ctx_o.top[i] = top_i[{bx, 2'(i)}];
            end else begin
                ctx_o.top[i] = recon[{by_up, 2'b11, bx, 2'(i)}];
            end
            if (bx == 2'd0) begin
                ctx_o.left[i] = left_i[{by, 2'(i)}];
            end else begin
                ctx_o.left[i] = recon[{by, 2'(i), bx_lf, 2'b11}];
            end
            for (int j = 0; j < intra4_pkg::BLK_ROWS; j++) begin
                src_blk_o[i*intra4_pkg::BLK_ROWS + j] = src_i[{by, 2'(i), bx, 2'(j)}];
            end
        end
    end

    // Corner pixel above and to the left
    always_comb begin
        case ({by == 2'd0, bx == 2'd0})
            2'b11:   ctx_o.top_left = top_left_i;
            2'b10:   ctx_o.top_left = top_i[{bx_lf, 2'b11}];
            2'b01:   ctx_o.top_left = left_i[{by_up, 2'b11}];
            default: ctx_o.top_left = recon[{by_up, 2'b11, bx_lf, 2'b11}];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon <= '0;
        end else if (store_en_i) begin
            for (int i = 0; i < intra4_pkg::BLK_ROWS; i++) begin
                for (int j = 0; j < intra4_pkg::BLK_ROWS; j++) begin
                    recon[{by, 2'(i), bx, 2'(j)}] <= best_blk_i[i*intra4_pkg::BLK_ROWS + j];
                end
            end
        end
    end

    assign yout_o = recon;

endmodule

// ==== design/intra4_ctrl.sv ====
/*
 * Intra 4x4 sequencer
 * Walks the subblocks row by row, holds the scored pair and sums the total
 */
module intra4_ctrl (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start_i,
    input  intra4_pkg::lambda_t                          lambda_i,
    input  intra4_pkg::pred_set_t                        preds_i,
    input  intra4_pkg::blk4_t                            src_blk_i,
    input  intra4_pkg::mode_e                            best_mode_i,
    input  intra4_pkg::score_t                           best_score_i,
    output intra4_pkg::blk_idx_t                         blk_idx_o,
    output logic [1:0]                                   row_o,
    output logic                                         acc_clr_o,
    output logic                                         acc_en_o,
    output logic                                         capture_o,
    output logic                                         store_en_o,
    output intra4_pkg::pred_set_t                        preds_hold_o,
    output intra4_pkg::blk4_t                            src_hold_o,
    output intra4_pkg::mode_e [intra4_pkg::NUM_BLKS-1:0] modes_o,
    output intra4_pkg::score_t                           score_o,
    output logic                                         done_o
);

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        PRED,
        ACC,
        BEST,
        STORE,
        DONE
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_i) state_nxt = INIT;
            INIT:    state_nxt = PRED;
            PRED:    state_nxt = ACC;
            ACC:     if (row_o == 2'(intra4_pkg::BLK_ROWS - 1)) state_nxt = BEST;
            BEST:    state_nxt = STORE;
            STORE: begin
                if (blk_idx_o == 4'(intra4_pkg::NUM_BLKS - 1)) begin
                    state_nxt = DONE;
                end else begin
                    state_nxt = PRED;
                end
            end
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Strobes decoded from the state
    assign acc_clr_o  = (state == PRED);
    assign acc_en_o   = (state == ACC);
    assign capture_o  = (state == BEST);
    assign store_en_o = (state == STORE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            blk_idx_o <= '0;
            row_o     <= '0;
            modes_o   <= '0;
            score_o   <= '0;
            done_o    <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_o <= (state == DONE);
            case (state)
                INIT: begin
                    blk_idx_o <= '0;
                    score_o   <= intra4_pkg::score_t'(intra4_pkg::MB_BASE_COST) *
                                 intra4_pkg::score_t'(lambda_i);
                end
                PRED:  row_o <= '0;
                ACC:   row_o <= row_o + 2'd1;
                STORE: begin
                    modes_o[blk_idx_o] <= best_mode_i;
                    score_o            <= score_o + best_score_i;
                    blk_idx_o          <= blk_idx_o + 4'd1;
                end
                default: ;
            endcase
        end
    end

    // Stable predictions and source for the accumulators
    always_ff @(posedge clk) begin
        if (state == PRED) begin
            preds_hold_o <= preds_i;
            src_hold_o   <= src_blk_i;
        end
    end

endmodule

// ==== design/intra4_mode_select.sv ====
/*
 * Mode selector
 * Scores each mode and registers the cheapest, lower mode wins a tie
 */
module intra4_mode_select (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        capture_i,
    input  intra4_pkg::lambda_t                         lambda_i,
    input  intra4_pkg::sse_t [intra4_pkg::NUM_MODES-1:0] sse_i,
    input  intra4_pkg::pred_set_t                       preds_i,
    output intra4_pkg::mode_e                           best_mode_o,
    output intra4_pkg::score_t                          best_score_o,
    output intra4_pkg::blk4_t                           best_blk_o
);

    intra4_pkg::score_t [intra4_pkg::NUM_MODES-1:0] score;
    intra4_pkg::mode_e                              sel_mode;
    intra4_pkg::score_t                             sel_score;

    // Distortion scaled by 256 plus header cost times lambda
    always_comb begin
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            score[m] = (intra4_pkg::score_t'(sse_i[m]) << intra4_pkg::SSE_SHIFT)
                     + intra4_pkg::score_t'(intra4_pkg::MODE_COST[m])
                     * intra4_pkg::score_t'(lambda_i);
        end
    end

    // Strict compare keeps the earlier mode on a tie
    always_comb begin
        sel_mode  = intra4_pkg::I4_DC;
        sel_score = score[0];
        for (int m = 1; m < intra4_pkg::NUM_MODES; m++) begin
            if (score[m] < sel_score) begin
                sel_mode  = intra4_pkg::mode_e'(m);
                sel_score = score[m];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_mode_o  <= intra4_pkg::I4_DC;
            best_score_o <= '0;
        end else if (capture_i) begin
            best_mode_o  <= sel_mode;
            best_score_o <= sel_score;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_i) begin
            best_blk_o <= preds_i[sel_mode];
        end
    end

endmodule

// ==== design/intra4_pkg.sv ====
/*
 * Intra 4x4 mode decision package
 * Pixel, block, context, mode and score types with the mode cost table
 */
package intra4_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int NUM_MODES    = 4;
    localparam int BLK_ROWS     = 4;
    localparam int NUM_BLKS     = 16;
    localparam int MB_BASE_COST = 211;
    localparam int SSE_SHIFT    = 8;

    // ----------------------------------------
    // Pixel and block types
    // ----------------------------------------
    typedef logic [7:0] pix_t;
    typedef pix_t [BLK_ROWS-1:0] edge4_t;
    // Raster order, index is row * 4 + column
    typedef pix_t [BLK_ROWS*BLK_ROWS-1:0] blk4_t;
    // Raster order, index is y * 16 + x
    typedef pix_t [255:0] mb_t;

    // Neighbor pixels of one subblock
    typedef struct packed {
        pix_t   top_left;
        edge4_t top;
        edge4_t left;
    } ctx_t;

    typedef enum logic [1:0] {
        I4_DC = 2'd0,
        I4_TM = 2'd1,
        I4_VE = 2'd2,
        I4_HE = 2'd3
    } mode_e;

    typedef blk4_t [NUM_MODES-1:0] pred_set_t;

    typedef logic [19:0] sse_t;
    typedef logic [39:0] score_t;
    typedef logic [15:0] lambda_t;
    typedef logic [3:0]  blk_idx_t;

    // Fixed header cost per mode, indexed by mode_e
    localparam logic [NUM_MODES-1:0][10:0] MODE_COST = {
        11'd1874, 11'd1723, 11'd1151, 11'd40
    };

endpackage

// ==== design/intra4_predict.sv ====
/*
 * 4x4 intra predictors
 * DC, TM, VE and HE built from one subblock's neighbor context
 */
module intra4_predict (
    input  intra4_pkg::ctx_t      ctx_i,
    output intra4_pkg::pred_set_t preds_o
);

    localparam int N = intra4_pkg::BLK_ROWS;

    // ----------------------------------------
    // DC
    // ----------------------------------------
    logic [10:0]      dc_sum;
    intra4_pkg::pix_t dc_val;

    always_comb begin
        // Rounding term
        dc_sum = 11'd4;
        for (int i = 0; i < N; i++) begin
            dc_sum = dc_sum + 11'(ctx_i.top[i]) + 11'(ctx_i.left[i]);
        end
    end

    assign dc_val = dc_sum[10:3];

    // ----------------------------------------
    // All four modes
    // ----------------------------------------
    always_comb begin
        logic signed [9:0] tm;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                tm = signed'({2'b00, ctx_i.left[r]}) + signed'({2'b00, ctx_i.top[c]})
                   - signed'({2'b00, ctx_i.top_left});
                if (tm < 0) begin
                    preds_o[intra4_pkg::I4_TM][r*N + c] = 8'd0;
                end else if (tm > 10'sd255) begin
                    preds_o[intra4_pkg::I4_TM][r*N + c] = 8'd255;
                end else begin
                    preds_o[intra4_pkg::I4_TM][r*N + c] = tm[7:0];
                end
                preds_o[intra4_pkg::I4_DC][r*N + c] = dc_val;
                // Plain copies, no smoothing
                preds_o[intra4_pkg::I4_VE][r*N + c] = ctx_i.top[c];
                preds_o[intra4_pkg::I4_HE][r*N + c] = ctx_i.left[r];
            end
        end
    end

endmodule

// ==== design/intra4_sse_acc.sv ====
/*
 * Squared error accumulator
 * Adds one row of a 4x4 prediction error per enabled cycle
 */
module intra4_sse_acc (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clr_i,
    input  logic              en_i,
    input  logic [1:0]        row_i,
    input  intra4_pkg::blk4_t pred_i,
    input  intra4_pkg::blk4_t src_i,
    output intra4_pkg::sse_t  sse_o
);

    intra4_pkg::sse_t row_sse;

    always_comb begin
        intra4_pkg::pix_t p;
        intra4_pkg::pix_t s;
        intra4_pkg::pix_t ad;
        row_sse = '0;
        for (int c = 0; c < intra4_pkg::BLK_ROWS; c++) begin
            p  = pred_i[{row_i, 2'(c)}];
            s  = src_i[{row_i, 2'(c)}];
            ad = (p > s) ? p - s : s - p;
            row_sse = row_sse + intra4_pkg::sse_t'(ad) * intra4_pkg::sse_t'(ad);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sse_o <= '0;
        end else if (clr_i) begin
            sse_o <= '0;
        end else if (en_i) begin
            sse_o <= sse_o + row_sse;
        end
    end

endmodule

// ==== design/intra4_top.sv ====
/*
 * Intra 4x4 luma mode decision for one 16x16 macroblock
 * Picks DC, TM, VE or HE per subblock and builds the reconstruction
 */
module intra4_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start_i,
    input  intra4_pkg::lambda_t                          lambda_i,
    input  intra4_pkg::mb_t                              src_i,
    input  intra4_pkg::pix_t                             top_left_i,
    input  intra4_pkg::pix_t [15:0]                      top_i,
    input  intra4_pkg::pix_t [15:0]                      left_i,
    output intra4_pkg::mb_t                              yout_o,
    output intra4_pkg::mode_e [intra4_pkg::NUM_BLKS-1:0] modes_o,
    output intra4_pkg::score_t                           score_o,
    output logic                                         done_o
);

    intra4_pkg::blk_idx_t                          blk_idx;
    logic [1:0]                                    row;
    logic                                          acc_clr;
    logic                                          acc_en;
    logic                                          capture;
    logic                                          store_en;
    intra4_pkg::ctx_t                              ctx;
    intra4_pkg::blk4_t                             src_blk;
    intra4_pkg::blk4_t                             src_hold;
    intra4_pkg::pred_set_t                         preds;
    intra4_pkg::pred_set_t                         preds_hold;
    intra4_pkg::sse_t [intra4_pkg::NUM_MODES-1:0]  sse;
    intra4_pkg::mode_e                             best_mode;
    intra4_pkg::score_t                            best_score;
    intra4_pkg::blk4_t                             best_blk;

    intra4_ctrl ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .lambda_i     (lambda_i),
        .preds_i      (preds),
        .src_blk_i    (src_blk),
        .best_mode_i  (best_mode),
        .best_score_i (best_score),
        .blk_idx_o    (blk_idx),
        .row_o        (row),
        .acc_clr_o    (acc_clr),
        .acc_en_o     (acc_en),
        .capture_o    (capture),
        .store_en_o   (store_en),
        .preds_hold_o (preds_hold),
        .src_hold_o   (src_hold),
        .modes_o      (modes_o),
        .score_o      (score_o),
        .done_o       (done_o)
    );

    intra4_context context_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .store_en_i (store_en),
        .blk_idx_i  (blk_idx),
        .best_blk_i (best_blk),
        .src_i      (src_i),
        .top_left_i (top_left_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .ctx_o      (ctx),
        .src_blk_o  (src_blk),
        .yout_o     (yout_o)
    );

    intra4_predict predict_inst (
        .ctx_i   (ctx),
        .preds_o (preds)
    );

    // One accumulator per mode
    for (genvar m = 0; m < intra4_pkg::NUM_MODES; m++) begin : g_sse
        intra4_sse_acc sse_acc_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .clr_i  (acc_clr),
            .en_i   (acc_en),
            .row_i  (row),
            .pred_i (preds_hold[m]),
            .src_i  (src_hold),
            .sse_o  (sse[m])
        );
    end

    intra4_mode_select mode_select_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture_i    (capture),
        .lambda_i     (lambda_i),
        .sse_i        (sse),
        .preds_i      (preds_hold),
        .best_mode_o  (best_mode),
        .best_score_o (best_score),
        .best_blk_o   (best_blk)
    );

endmodule

// ==== dv/intra4_model.svh ====
/*
 * Reference model of the intra 4x4 mode decision
 * Walks the subblocks in raster order on its own reconstruction
 */
`ifndef INTRA4_MODEL_SVH
`define INTRA4_MODEL_SVH

// Pixel at (y, x), row -1 is the top edge and column -1 the left edge
function automatic int edge_or_recon(input intra4_pkg::mb_t rec, input intra4_pkg::pix_t tl,
                                     input intra4_pkg::pix_t [15:0] top,
                                     input intra4_pkg::pix_t [15:0] left,
                                     input int y, input int x);
    if (y < 0 && x < 0) begin
        return int'(tl);
    end
    if (y < 0) begin
        return int'(top[x]);
    end
    if (x < 0) begin
        return int'(left[y]);
    end
    return int'(rec[y * 16 + x]);
endfunction

function automatic int clip_pixel(input int v);
    if (v < 0) begin
        return 0;
    end
    return (v > 255) ? 255 : v;
endfunction

task automatic model_mb(input intra4_pkg::mb_t src, input intra4_pkg::pix_t tl,
                        input intra4_pkg::pix_t [15:0] top,
                        input intra4_pkg::pix_t [15:0] left,
                        input intra4_pkg::lambda_t lam,
                        output intra4_pkg::mb_t rec,
                        output intra4_pkg::mode_e [15:0] modes,
                        output intra4_pkg::score_t total);
    int     cost [4];
    int     t [4];
    int     l [4];
    int     pred [4][16];
    int     corner;
    int     dc;
    int     sse;
    int     diff;
    int     best;
    int     y0;
    int     x0;
    longint sc;
    longint best_sc;
    longint tot;
    cost = '{40, 1151, 1723, 1874};
    rec  = '0;
    tot  = 211 * longint'(lam);
    for (int b = 0; b < 16; b++) begin
        y0     = (b / 4) * 4;
        x0     = (b % 4) * 4;
        corner = edge_or_recon(rec, tl, top, left, y0 - 1, x0 - 1);
        dc     = 4;
        for (int i = 0; i < 4; i++) begin
            t[i] = edge_or_recon(rec, tl, top, left, y0 - 1, x0 + i);
            l[i] = edge_or_recon(rec, tl, top, left, y0 + i, x0 - 1);
            dc   = dc + t[i] + l[i];
        end
        // Mode order DC, TM, VE, HE
        for (int k = 0; k < 16; k++) begin
            pred[0][k] = dc / 8;
            pred[1][k] = clip_pixel(l[k / 4] + t[k % 4] - corner);
            pred[2][k] = t[k % 4];
            pred[3][k] = l[k / 4];
        end
        best    = 0;
        best_sc = 0;
        for (int m = 0; m < 4; m++) begin
            sse = 0;
            for (int k = 0; k < 16; k++) begin
                diff = int'(src[(y0 + k / 4) * 16 + x0 + k % 4]) - pred[m][k];
                sse  = sse + diff * diff;
            end
            sc = longint'(sse) * 256 + longint'(cost[m]) * longint'(lam);
            if (m == 0 || sc < best_sc) begin
                best    = m;
                best_sc = sc;
            end
        end
        modes[b] = intra4_pkg::mode_e'(2'(best));
        tot      = tot + best_sc;
        for (int k = 0; k < 16; k++) begin
            rec[(y0 + k / 4) * 16 + x0 + k % 4] = 8'(pred[best][k]);
        end
    end
    total = intra4_pkg::score_t'(tot);
endtask

`endif

// ==== dv/intra4_tb.sv ====
/*
 * Testbench for the intra 4x4 mode decision
 * Runs fixed and random macroblocks and checks them against a reference model
 */
module intra4_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 10;
    localparam int DONE_EDGES     = 114;
    localparam int NUM_RUNS       = 8;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * 120 + 200;

    logic                          clk;
    logic                          rst_n;
    logic                          start_i;
    intra4_pkg::lambda_t           lambda_i;
    intra4_pkg::mb_t               src_i;
    intra4_pkg::pix_t              top_left_i;
    intra4_pkg::pix_t [15:0]       top_i;
    intra4_pkg::pix_t [15:0]       left_i;
    intra4_pkg::mb_t               yout_o;
    intra4_pkg::mode_e [15:0]      modes_o;
    intra4_pkg::score_t            score_o;
    logic                          done_o;

    int                            seed = 32'hc06a_7f7f;
    int                            errors = 0;
    int                            checks = 0;
    int                            cycles = 0;
    intra4_pkg::mode_e [15:0]      modes_lam0;

    `include "intra4_model.svh"

    intra4_top intra4_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .lambda_i   (lambda_i),
        .src_i      (src_i),
        .top_left_i (top_left_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .yout_o     (yout_o),
        .modes_o    (modes_o),
        .score_o    (score_o),
        .done_o     (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
    else begin
        errors++;
        $display("Error at %0t: done_o = 1, expected 0 one cycle after done", $time);
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_value(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Check failed at %0t: %s", $time, what);
        end
    endtask

    task automatic compare_with_model();
        intra4_pkg::mb_t          exp_yout;
        intra4_pkg::mode_e [15:0] exp_modes;
        intra4_pkg::score_t       exp_score;
        model_mb(src_i, top_left_i, top_i, left_i, lambda_i, exp_yout, exp_modes, exp_score);
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("yout_o[%0d]", i), longint'(yout_o[i]), longint'(exp_yout[i]));
        end
        for (int b = 0; b < 16; b++) begin
            check_value($sformatf("modes_o[%0d]", b), longint'(modes_o[b]),
                        longint'(exp_modes[b]));
        end
        check_value("score_o", longint'(score_o), longint'(exp_score));
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic run_mb(input logic second_start);
        int edges;
        edges = 0;
        @(posedge clk);
        #DRIVE_DLY start_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY start_i = 1'b0;
        while (!done_o && edges < DONE_EDGES + 20) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
            // Busy runs must ignore this pulse
            start_i = second_start && (edges == 40);
        end
        check_true(done_o, "done_o did not rise after start");
        check_value("done_o latency", longint'(edges), longint'(DONE_EDGES));
        compare_with_model();
        if (second_start) begin
            // Long enough for a run started by the ignored pulse to finish
            repeat (DONE_EDGES + 4) begin
                @(posedge clk);
                #DRIVE_DLY;
                check_true(!done_o, "done_o rose again after the run had ended");
            end
        end
    endtask

    task automatic random_picture();
        for (int i = 0; i < 256; i++) begin
            src_i[i] = 8'($random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            top_i[i]  = 8'($random(seed));
            left_i[i] = 8'($random(seed));
        end
        top_left_i = 8'($random(seed));
        lambda_i   = 16'($random(seed)) & 16'h03ff;
    endtask

    // Stripes match one edge and the other edge alternates so TM differs
    task automatic stripe_picture(input logic vertical);
        intra4_pkg::pix_t ramp;
        intra4_pkg::pix_t alt;
        for (int i = 0; i < 16; i++) begin
            ramp = 8'(i * 16);
            alt  = (i % 2 == 1) ? 8'd200 : 8'd40;
            for (int j = 0; j < 16; j++) begin
                src_i[i * 16 + j] = vertical ? 8'(j * 16) : ramp;
            end
            top_i[i]  = vertical ? ramp : alt;
            left_i[i] = vertical ? alt : ramp;
        end
        top_left_i = 8'd120;
        lambda_i   = 16'd100;
    endtask

    initial begin
        rst_n      = 1'b0;
        start_i    = 1'b0;
        lambda_i   = '0;
        src_i      = '0;
        top_left_i = '0;
        top_i      = '0;
        left_i     = '0;
        repeat (16) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;

        check_true(!done_o, "done_o is high after reset");
        check_value("score_o", longint'(score_o), 0);
        check_true(modes_o == '0, "modes_o is not zero after reset");
        check_true(yout_o == '0, "yout_o is not zero after reset");

        src_i      = {256{8'd128}};
        top_i      = {16{8'd128}};
        left_i     = {16{8'd128}};
        top_left_i = 8'd128;
        lambda_i   = 16'd37;
        run_mb(1'b0);
        check_true(yout_o == src_i, "flat picture: yout_o differs from src_i");
        check_true(modes_o == '0, "flat picture: a mode other than I4_DC was chosen");
        check_value("score_o", longint'(score_o), (211 + 16 * 40) * 37);

        // Past the first column or row TM equals the copy mode at a lower cost
        stripe_picture(1'b1);
        run_mb(1'b0);
        check_true(yout_o == src_i, "vertical stripes: yout_o differs from src_i");
        for (int b = 0; b < 16; b++) begin
            if (b % 4 == 0) begin
                check_value($sformatf("modes_o[%0d]", b), longint'(modes_o[b]),
                            longint'(intra4_pkg::I4_VE));
            end else begin
                check_true(modes_o[b] inside {intra4_pkg::I4_VE, intra4_pkg::I4_TM},
                           "vertical stripes: a subblock chose neither VE nor TM");
            end
        end
        stripe_picture(1'b0);
        run_mb(1'b0);
        check_true(yout_o == src_i, "horizontal stripes: yout_o differs from src_i");
        for (int b = 0; b < 16; b++) begin
            if (b < 4) begin
                check_value($sformatf("modes_o[%0d]", b), longint'(modes_o[b]),
                            longint'(intra4_pkg::I4_HE));
            end else begin
                check_true(modes_o[b] inside {intra4_pkg::I4_HE, intra4_pkg::I4_TM},
                           "horizontal stripes: a subblock chose neither HE nor TM");
            end
        end

        random_picture();
        run_mb(1'b0);
        random_picture();
        run_mb(1'b0);
        random_picture();
        run_mb(1'b1);

        random_picture();
        lambda_i = 16'd0;
        run_mb(1'b0);
        modes_lam0 = modes_o;
        lambda_i   = 16'hffff;
        run_mb(1'b0);
        check_true(modes_o != modes_lam0,
                   "lambda 0 and lambda 65535 chose the same modes for this seed");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== intra4_top.f ====
+incdir+dv
design/intra4_pkg.sv
design/intra4_predict.sv
design/intra4_sse_acc.sv
design/intra4_mode_select.sv
design/intra4_context.sv
design/intra4_ctrl.sv
design/intra4_top.sv
dv/intra4_tb.sv
